// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= pipelineTb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/pipeTrace.txt ====
# P <instruction word, hex>  (bits 31..28 MOV SUB3 ADD4 ADD1, 7..4 dst, 3..0 src)
# E <destination register, hex> <written value, hex>, one per writeback in order
P 20000010 # ADD4 r1 <- r0
P 40000020 # SUB3 r2 <- r0, wraps below zero
P 10000030 # ADD1 r3 <- r0
P 80000041 # MOV  r4 <- r1, write-through read
P 00000000 # NOP
P 40000054 # SUB3 r5 <- r4, WB into EX1 past a NOP
P 40000065 # SUB3 r6 <- r5, EX2 into EX1
P 80000063 # MOV  r6 <- r3
P 40000076 # SUB3 r7 <- r6, EX2 wins over WB
P 80000087 # MOV  r8 <- r7
P 20000098 # ADD4 r9 <- r8
P 400000A9 # SUB3 r10 <- r9, stall
P 100000B9 # ADD1 r11 <- r9
P 100000CB # ADD1 r12 <- r11, stall
P 400000DC # SUB3 r13 <- r12, stall
P 40000012 # SUB3 r1 <- r2
P 20000024 # ADD4 r2 <- r4
P 200000F1 # ADD4 r15 <- r1, two ahead
P 200000EF # ADD4 r14 <- r15, WB into EX2
P 800000DE # MOV  r13 <- r14, WB into EX2
P 100000CD # ADD1 r12 <- r13
P 800000BC # MOV  r11 <- r12, WB into EX2
P 200000AC # ADD4 r10 <- r12, two ahead
P 8000009C # MOV  r9 <- r12, write-through read
E 1 0004
E 2 FFFD
E 3 0001
E 4 0004
E 5 0001
E 6 FFFE
E 6 0001
E 7 FFFE
E 8 FFFE
E 9 0002
E a FFFF
E b 0003
E c 0004
E d 0001
E 1 FFFA
E 2 0008
E f FFFE
E e 0002
E d 0002
E c 0003
E b 0003
E a 0007
E 9 0003

// ==== tb/pipe_asserts.sv ====
`timescale 1ns/1ns

module pipeAsserts (
	input logic CLK,
	input logic RSTB,
	input pipePkg::wbT wb,
	input logic stall
);

	// --------------------------------------------------
	// Stall and writeback properties
	// --------------------------------------------------
	// After one stall the bubble sits in EX1, so the consumer no longer
	// sees its producer there and must move on
	stallOneCycle: assert property (@(posedge CLK) disable iff (!RSTB) stall |=> !stall)
		else $error("stall was high for two cycles in a row");

	// The EX2/WB register is cleared, nothing may reach the register file
	quietWbInReset: assert property (@(posedge CLK) !RSTB |-> !wb.write)
		else $error("wb write high while RSTB is low");

	// The bubble inserted by a stall walks through EX1 and EX2
	// and leaves one empty writeback slot three cycles later
	bubbleReachesWb: assert property (@(posedge CLK) disable iff (!RSTB) stall |-> ##3 !wb.write)
		else $error("no empty wb slot three cycles after a stall");

endmodule

// ==== tb/pipelineTb.sv ====
`timescale 1ns/1ns

module pipelineTb;

	localparam string TRACE_FILE = "tb/pipeTrace.txt";
	localparam int RESET_CYCLES = 3;
	localparam int DRAIN_CYCLES = 10;

	logic CLK;
	logic RSTB;
	logic imemWrite;
	pipePkg::pcT imemAddr;
	pipePkg::instrT imemData;
	logic run;
	pipePkg::wbT wb;
	logic stall;

	// Program image and the writebacks it should produce, both from the trace
	pipePkg::instrT progWords [$];
	pipePkg::wbT expWrites [$];
	int wbIndex = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	pipelineTop i_pipelineTop (
		.CLK(CLK),
		.RSTB(RSTB),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.run(run),
		.wb(wb),
		.stall(stall)
	);

	bind pipelineTop pipeAsserts i_pipeAsserts (
		.CLK(CLK),
		.RSTB(RSTB),
		.wb(wb),
		.stall(stall)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#2 CLK = ~CLK;
	end

	// Run phase limit, roughly four cycles per word plus the pipeline fill and drain
	always @(posedge CLK)
	begin
		if (run)
		begin
			cycleCount <= cycleCount + 1;
			if (cycleCount >= cycleLimit)
			begin
				$display("Timeout after %0d cycles of run, results still missing", cycleCount);
				$display("TEST RESULT: FAIL");
				$fatal(1, "Run did not finish in time");
			end
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic reportFailure(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first failing check");
	endtask

	// Every strobe must match the next result in program order
	task automatic checkWb(input pipePkg::wbT got);
		pipePkg::wbT exp;
		exp = expWrites.pop_front();
		if (got.dst !== exp.dst || got.data !== exp.data)
			reportFailure($sformatf("write %0d is r%0d = %h, expected r%0d = %h",
				wbIndex, got.dst, got.data, exp.dst, exp.data));
		wbIndex++;
	endtask

	task automatic checkQuiet(input logic value, input string what);
		if (value !== 1'b0)
			reportFailure($sformatf("%s is high, expected low", what));
	endtask

	// --------------------------------------------------
	// Trace reader
	// --------------------------------------------------
	// P lines carry instruction words, E lines a register number and value
	task automatic readTrace();
		int fd;
		int code;
		string line;
		logic [31:0] word;
		logic [31:0] regNum;
		logic [31:0] value;
		pipePkg::wbT entry;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file %s", TRACE_FILE);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Trace file missing");
		end
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 0)
			begin
				if (line[0] == "P")
				begin
					code = $sscanf(line, "P %h", word);
					progWords.push_back(pipePkg::instrT'(word));
				end
				else if (line[0] == "E")
				begin
					code = $sscanf(line, "E %h %h", regNum, value);
					entry.write = 1'b1;
					entry.dst = pipePkg::regIdT'(regNum);
					entry.data = pipePkg::dataT'(value);
					expWrites.push_back(entry);
				end
			end
		end
		$fclose(fd);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		RSTB = 1'b0;
		imemWrite = 1'b0;
		imemAddr = '0;
		imemData = '0;
		run = 1'b0;
		readTrace();
		cycleLimit = 4 * progWords.size() + 30;
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTB <= 1'b1;

		// Whole memory is written, words past the program become NOPs
		// The pipeline must stay idle the whole time run is low
		for (int addr = 0; addr < pipePkg::IMEM_DEPTH; addr++)
		begin
			@(posedge CLK);
			imemWrite <= 1'b1;
			imemAddr <= pipePkg::pcT'(addr);
			imemData <= (addr < progWords.size()) ? progWords[addr] : '0;
			@(negedge CLK);
			checkQuiet(wb.write, "wb write while loading");
			checkQuiet(stall, "stall while loading");
		end

		@(posedge CLK);
		imemWrite <= 1'b0;
		run <= 1'b1;

		// Outputs change on the rising edge, so they are read on the falling one
		while (expWrites.size() > 0)
		begin
			@(negedge CLK);
			if (wb.write)
				checkWb(wb);
		end

		// Only NOPs are left in the memory
		repeat (DRAIN_CYCLES)
		begin
			@(negedge CLK);
			checkQuiet(wb.write, "wb write after the last expected result");
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/ex1Stage.sv
verilog/ex2Stage.sv
verilog/pipelineTop.sv
tb/pipe_asserts.sv
tb/pipelineTb.sv

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
	input logic CLK,
	input logic RSTB,
	input pipePkg::opFlagsT idOps,
	input pipePkg::regIdT idSrc,
	input pipePkg::regIdT idDst,
	input pipePkg::ex1Ex2T ex2,
	input pipePkg::wbT wb,
	output logic stall,
	output pipePkg::idEx1T ex1
);

	pipePkg::dataT regFile [pipePkg::REG_COUNT];
	pipePkg::dataT srcData;
	// Source compares against the destinations further down the pipe
	logic matchEx1;
	logic matchEx2;

	// --------------------------------------------------
	// Register file
	// --------------------------------------------------
	// Cleared on reset so a program starts from all zeros
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			for (int i = 0; i < pipePkg::REG_COUNT; i++)
				regFile[i] <= '0;
		end
		else if (wb.write)
		begin
			regFile[wb.dst] <= wb.data;
		end
	end

	// The WB write lands at the end of this cycle, so a same-cycle read
	// of that register takes the value straight off the writeback bus
	always_comb
	begin
		if (wb.write && (wb.dst == idSrc))
			srcData = wb.data;
		else
			srcData = regFile[idSrc];
	end

	// --------------------------------------------------
	// Dependency detection
	// --------------------------------------------------
	assign matchEx1 = (idSrc == ex1.dst);
	assign matchEx2 = (idSrc == ex2.dst);

	// A SUB3 or ADD1 needs its operand at the start of EX1
	// An ADD4 or ADD1 in EX1 only has its result at the end of EX2
	// When both meet on the same register the consumer waits one cycle
	assign stall = matchEx1 && (idOps.sub3 || idOps.add1)
		&& (ex1.ops.add4 || ex1.ops.add1);

	// --------------------------------------------------
	// ID/EX1 register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex1 <= '0;
		end
		else
		begin
			// Zero flags turn the stalled slot into a bubble
			ex1.ops <= stall ? '0 : idOps;
			ex1.dst <= idDst;
			ex1.srcData <= srcData;
			ex1.matchEx1 <= matchEx1;
			ex1.matchEx2 <= matchEx2;
		end
	end

endmodule

// ==== verilog/ex1Stage.sv ====
`timescale 1ns/1ns

module ex1Stage (
	input logic CLK,
	input logic RSTB,
	input pipePkg::idEx1T ex1,
	input pipePkg::dataT ex2ForwardData,
	input pipePkg::wbT wb,
	output pipePkg::ex1Ex2T ex2
);

	logic takeEx2;
	logic takeWb;
	pipePkg::dataT operand;
	pipePkg::dataT result;

	// --------------------------------------------------
	// Operand forwarding
	// --------------------------------------------------
	// EX2 is the younger producer, so it wins over WB
	// Only SUB3 and MOV have a finished value while in EX2
	assign takeEx2 = ex1.matchEx1 && (ex2.ops.sub3 || ex2.ops.mov);
	assign takeWb = ex1.matchEx2 && wb.write;

	always_comb
	begin
		if (takeEx2)
			operand = ex2ForwardData;
		else if (takeWb)
			operand = wb.data;
		else
			operand = ex1.srcData;
	end

	// Subtract for SUB3 and ADD1, others skip the unit
	always_comb
	begin
		if (ex1.ops.sub3 || ex1.ops.add1)
			result = operand - pipePkg::SUB_AMOUNT;
		else
			result = operand;
	end

	// --------------------------------------------------
	// EX1/EX2 register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex2 <= '0;
		end
		else
		begin
			ex2.ops <= ex1.ops;
			ex2.dst <= ex1.dst;
			ex2.data <= result;
			// EX2 needs to know if its source was the instruction now entering WB
			ex2.matchEx1 <= ex1.matchEx1;
		end
	end

endmodule

// ==== verilog/ex2Stage.sv ====
`timescale 1ns/1ns

module ex2Stage (
	input logic CLK,
	input logic RSTB,
	input pipePkg::ex1Ex2T ex2,
	input pipePkg::wbT wb,
	output pipePkg::dataT ex2ForwardData,
	output pipePkg::wbT wbOut
);

	logic takeWb;
	pipePkg::dataT result;

	// ADD4 and MOV skipped EX1, so a producer now in WB may still be
	// owed to them here
	assign takeWb = ex2.matchEx1 && (ex2.ops.add4 || ex2.ops.mov) && wb.write;

	// Corrected value, also what EX1 sees when it forwards from EX2
	assign ex2ForwardData = takeWb ? wb.data : ex2.data;

	// Add for ADD4 and ADD1, others skip the unit
	always_comb
	begin
		if (ex2.ops.add4 || ex2.ops.add1)
			result = ex2ForwardData + pipePkg::ADD_AMOUNT;
		else
			result = ex2ForwardData;
	end

	// --------------------------------------------------
	// EX2/WB register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			wbOut <= '0;
		end
		else
		begin
			// Every real instruction writes, bubbles and NOPs do not
			wbOut.write <= |ex2.ops;
			wbOut.dst <= ex2.dst;
			wbOut.data <= result;
		end
	end

endmodule

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage (
	input logic CLK,
	input logic RSTB,
	input logic imemWrite,
	input pipePkg::pcT imemAddr,
	input pipePkg::instrT imemData,
	input logic run,
	input logic stall,
	output pipePkg::opFlagsT idOps,
	output pipePkg::regIdT idSrc,
	output pipePkg::regIdT idDst
);

	// Instruction memory, filled by the loader before the run starts
	pipePkg::instrT imem [pipePkg::IMEM_DEPTH];
	pipePkg::pcT pc;
	pipePkg::instrT fetchWord;

	// Load port writes one word per clock
	always_ff @(posedge CLK)
	begin
		if (imemWrite)
			imem[imemAddr] <= imemData;
	end

	// Asynchronous read at the current PC
	assign fetchWord = imem[pc];

	// --------------------------------------------------
	// PC and IF/ID register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			pc <= '0;
			idOps <= '0;
			idSrc <= '0;
			idDst <= '0;
		end
		else if (!run)
		begin
			// Not running yet, so the PC waits and ID sees a bubble
			idOps <= '0;
		end
		else if (!stall)
		begin
			pc <= pc + 1'b1;
			idOps.mov <= fetchWord[pipePkg::MOV_BIT];
			idOps.sub3 <= fetchWord[pipePkg::SUB3_BIT];
			idOps.add4 <= fetchWord[pipePkg::ADD4_BIT];
			idOps.add1 <= fetchWord[pipePkg::ADD1_BIT];
			idSrc <= fetchWord[pipePkg::SRC_LSB +: pipePkg::REG_ID_WIDTH];
			idDst <= fetchWord[pipePkg::DST_LSB +: pipePkg::REG_ID_WIDTH];
		end
		// Under stall the PC and IF/ID keep their contents
	end

endmodule

// ==== verilog/pipePkg.sv ====
package pipePkg;

	// --------------------------------------------------
	// Sizes of the datapath and the two memories
	// --------------------------------------------------
	localparam int DATA_WIDTH = 16;
	localparam int REG_COUNT = 16;
	localparam int IMEM_DEPTH = 64;
	localparam int INSTR_WIDTH = 32;
	localparam int REG_ID_WIDTH = $clog2(REG_COUNT);
	localparam int PC_WIDTH = $clog2(IMEM_DEPTH);

	// One-hot opcode bits at the top of the word, a NOP has none of them set
	localparam int MOV_BIT = 31;
	localparam int SUB3_BIT = 30;
	localparam int ADD4_BIT = 29;
	localparam int ADD1_BIT = 28;

	// Register numbers live in the low byte of the word
	localparam int DST_LSB = 4;
	localparam int SRC_LSB = 0;

	typedef logic [DATA_WIDTH-1:0] dataT;
	typedef logic [REG_ID_WIDTH-1:0] regIdT;
	typedef logic [PC_WIDTH-1:0] pcT;
	typedef logic [INSTR_WIDTH-1:0] instrT;

	// Constants applied by the two arithmetic stages
	localparam dataT SUB_AMOUNT = dataT'(3);
	localparam dataT ADD_AMOUNT = dataT'(4);

	// --------------------------------------------------
	// Stage register contents
	// --------------------------------------------------
	typedef struct packed {
		logic mov;
		logic sub3;
		logic add4;
		logic add1;
	} opFlagsT;

	// Decoded instruction on its way into EX1
	typedef struct packed {
		opFlagsT ops;
		regIdT dst;
		dataT srcData;
		logic matchEx1;
		logic matchEx2;
	} idEx1T;

	// EX1 result on its way into EX2
	typedef struct packed {
		opFlagsT ops;
		regIdT dst;
		dataT data;
		logic matchEx1;
	} ex1Ex2T;

	// Writeback into the register file
	typedef struct packed {
		logic write;
		regIdT dst;
		dataT data;
	} wbT;

endpackage

// ==== verilog/pipelineTop.sv ====
`timescale 1ns/1ns

module pipelineTop (
	input logic CLK,
	input logic RSTB,
	input logic imemWrite,
	input pipePkg::pcT imemAddr,
	input pipePkg::instrT imemData,
	input logic run,
	output pipePkg::wbT wb,
	output logic stall
);

	// IF/ID fields
	pipePkg::opFlagsT idOps;
	pipePkg::regIdT idSrc;
	pipePkg::regIdT idDst;
	// Stage registers further down
	pipePkg::idEx1T ex1;
	pipePkg::ex1Ex2T ex2;
	// EX2 operand after its own WB forward, fed back to EX1
	pipePkg::dataT ex2ForwardData;

	// --------------------------------------------------
	// Stage instances
	// --------------------------------------------------
	fetchStage i_fetchStage (
		.CLK(CLK),
		.RSTB(RSTB),
		.imemWrite(imemWrite),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.run(run),
		.stall(stall),
		.idOps(idOps),
		.idSrc(idSrc),
		.idDst(idDst)
	);

	decodeStage i_decodeStage (
		.CLK(CLK),
		.RSTB(RSTB),
		.idOps(idOps),
		.idSrc(idSrc),
		.idDst(idDst),
		.ex2(ex2),
		.wb(wb),
		.stall(stall),
		.ex1(ex1)
	);

	ex1Stage i_ex1Stage (
		.CLK(CLK),
		.RSTB(RSTB),
		.ex1(ex1),
		.ex2ForwardData(ex2ForwardData),
		.wb(wb),
		.ex2(ex2)
	);

	// The writeback leaves here and is looped back into the stages above
	ex2Stage i_ex2Stage (
		.CLK(CLK),
		.RSTB(RSTB),
		.ex2(ex2),
		.wb(wb),
		.ex2ForwardData(ex2ForwardData),
		.wbOut(wb)
	);

endmodule
